/* hdl/z80_dp_pkg.sv */
// ---------------------------------------------------------------------------
// data widths and flag layout
// ---------------------------------------------------------------------------

// everything that travels on the internal data bus or the address path is
// built from these two types
package z80_dp_pkg;

  // one byte on the internal data bus, in a register or in the flag byte
  typedef logic [7:0] byte_t;

  // a register pair, the MAR or the value shown on the address output
  typedef logic [15:0] word_t;

  // bit positions inside the flag byte F
  // bits 5 and 3 are unused and only move with whole-byte loads
  localparam int FLAG_S  = 7;
  localparam int FLAG_Z  = 6;
  localparam int FLAG_H  = 4;
  localparam int FLAG_PV = 2;
  localparam int FLAG_N  = 1;
  localparam int FLAG_C  = 0;

  // value every register, shadow, TEMP and MAR byte takes during reset
  localparam byte_t RESET_BYTE = 8'h00;

endpackage

/* hdl/z80_ctrl_pkg.sv */
// ---------------------------------------------------------------------------
// control encodings
// ---------------------------------------------------------------------------

// selects and strobes that the sequencer drives into the datapath
package z80_ctrl_pkg;

  // byte registers held in the register file
  // the six general ones come first so they line up with their shadows
  typedef enum logic [3:0] {
    R_B   = 4'd0,
    R_C   = 4'd1,
    R_D   = 4'd2,
    R_E   = 4'd3,
    R_H   = 4'd4,
    R_L   = 4'd5,
    R_SPH = 4'd6,
    R_SPL = 4'd7,
    R_PCH = 4'd8,
    R_PCL = 4'd9
  } reg8_t;

  // number of byte registers and of shadowed general registers
  localparam int REG_COUNT    = 10;
  localparam int SHADOW_COUNT = 6;

  // register pairs as seen on the 16-bit address path
  typedef enum logic [2:0] {
    PAIR_BC = 3'd0,
    PAIR_DE = 3'd1,
    PAIR_HL = 3'd2,
    PAIR_SP = 3'd3,
    PAIR_PC = 3'd4
  } pair_t;

  // the one source allowed on the internal data bus in a cycle
  typedef enum logic [2:0] {
    DSRC_EXT  = 3'd0,
    DSRC_REG  = 3'd1,
    DSRC_A    = 3'd2,
    DSRC_F    = 3'd3,
    DSRC_TEMP = 3'd4
  } data_src_t;

  // what reaches the address output
  typedef enum logic {
    ASRC_MAR  = 1'b0,
    ASRC_PAIR = 1'b1
  } addr_src_t;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_ADC    = 4'd1,
    ALU_SUB    = 4'd2,
    ALU_AND    = 4'd3,
    ALU_INC_A  = 4'd4,
    ALU_INC_B  = 4'd5,
    ALU_CPL    = 4'd6,
    ALU_CCF    = 4'd7,
    ALU_PASS_B = 4'd8
  } alu_op_t;

  // per-flag override, 10 clears and 11 sets, anything else leaves it alone
  typedef enum logic [1:0] {
    FORCE_NONE = 2'b00,
    FORCE_CLR  = 2'b10,
    FORCE_SET  = 2'b11
  } force_t;

  typedef struct packed {
    force_t s;
    force_t z;
    force_t h;
    force_t pv;
    force_t n;
    force_t c;
  } flag_force_t;

  // full control word for one cycle of the datapath
  typedef struct packed {
    data_src_t   data_src;
    reg8_t       rd_reg;
    logic        ld_reg;
    reg8_t       wr_reg;
    pair_t       rd_pair;
    logic        ld_pair;
    pair_t       wr_pair;
    addr_src_t   addr_src;
    logic        exx;
    logic        ex_de_hl;
    alu_op_t     alu_op;
    logic        alu_b_temp;
    logic        res_from_alu;
    logic        ld_a;
    logic        ld_f;
    flag_force_t flag_force;
    logic        ex_af;
    logic        ld_temp;
    logic        ld_mar;
    logic        ld_marh;
    logic        ld_marl;
  } dp_ctrl_t;

endpackage

/* hdl/z80_regfile.sv */
`timescale 1ns/1ns

// byte registers B..L with shadows, plus SP and PC without shadows
// reads are combinational, one byte and one pair at a time
module z80_regfile import z80_dp_pkg::*, z80_ctrl_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  reg8_t rd_reg,
  input  reg8_t wr_reg,
  input  logic  ld_reg,
  input  logic  ld_pair,
  input  logic  exx,
  input  logic  ex_de_hl,
  input  byte_t wr_byte,
  input  pair_t rd_pair,
  input  pair_t wr_pair,
  input  word_t wr_word,
  output byte_t rd_byte,
  output word_t rd_word
);

  // indexed by reg8_t, so regs[R_H] is H
  byte_t regs [REG_COUNT];

  // shadow set for B, C, D, E, H and L in the same order
  byte_t shadow [SHADOW_COUNT];

  // ---------------------------------------------------------------------------
  // read side
  // ---------------------------------------------------------------------------

  // codes past R_PCL name no register and read as zero
  always_comb begin
    if (rd_reg <= R_PCL) begin
      rd_byte = regs[rd_reg];
    end else begin
      rd_byte = RESET_BYTE;
    end
  end

  // the H-named register of each pair is the upper byte of the word
  always_comb begin
    case (rd_pair)
      PAIR_BC: rd_word = {regs[R_B], regs[R_C]};
      PAIR_DE: rd_word = {regs[R_D], regs[R_E]};
      PAIR_HL: rd_word = {regs[R_H], regs[R_L]};
      PAIR_SP: rd_word = {regs[R_SPH], regs[R_SPL]};
      PAIR_PC: rd_word = {regs[R_PCH], regs[R_PCL]};
      default: rd_word = {RESET_BYTE, RESET_BYTE};
    endcase
  end

  // ---------------------------------------------------------------------------
  // write side
  // ---------------------------------------------------------------------------

  // exx beats ex_de_hl, which beats both loads
  // a byte load and a pair load on the same register leave the pair value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= RESET_BYTE;
      end
      for (int i = 0; i < SHADOW_COUNT; i++) begin
        shadow[i] <= RESET_BYTE;
      end
    end else if (exx) begin
      // all six general registers trade places with their shadows at once
      for (int i = 0; i < SHADOW_COUNT; i++) begin
        regs[i]   <= shadow[i];
        shadow[i] <= regs[i];
      end
    end else if (ex_de_hl) begin
      regs[R_D] <= regs[R_H];
      regs[R_E] <= regs[R_L];
      regs[R_H] <= regs[R_D];
      regs[R_L] <= regs[R_E];
    end else begin
      if (ld_reg && wr_reg <= R_PCL) begin
        regs[wr_reg] <= wr_byte;
      end
      if (ld_pair) begin
        // the upper half of the word goes to the H-named register
        case (wr_pair)
          PAIR_BC: begin
            regs[R_B] <= wr_word[15:8];
            regs[R_C] <= wr_word[7:0];
          end
          PAIR_DE: begin
            regs[R_D] <= wr_word[15:8];
            regs[R_E] <= wr_word[7:0];
          end
          PAIR_HL: begin
            regs[R_H] <= wr_word[15:8];
            regs[R_L] <= wr_word[7:0];
          end
          PAIR_SP: begin
            regs[R_SPH] <= wr_word[15:8];
            regs[R_SPL] <= wr_word[7:0];
          end
          PAIR_PC: begin
            regs[R_PCH] <= wr_word[15:8];
            regs[R_PCL] <= wr_word[7:0];
          end
          default: begin
            // unused pair codes write nothing
          end
        endcase
      end
    end
  end

endmodule

/* hdl/z80_alu8.sv */
`timescale 1ns/1ns

// combinational 8-bit ALU
// a is the accumulator, b is TEMP or the bus, f_in is the current F
module z80_alu8 import z80_dp_pkg::*, z80_ctrl_pkg::*; (
  input  alu_op_t op,
  input  byte_t   a,
  input  byte_t   b,
  input  byte_t   f_in,
  output byte_t   result,
  output byte_t   f_out
);

  logic       carry_in;
  logic [4:0] lo_sum;
  logic [4:0] hi_sum;
  logic [8:0] diff;
  byte_t      inc_src;
  byte_t      inc_sum;

  // ---------------------------------------------------------------------------
  // shared arithmetic
  // ---------------------------------------------------------------------------

  // the add is split at the nibble so the bit 3 carry is available for H
  assign carry_in = (op == ALU_ADC) ? f_in[FLAG_C] : 1'b0;
  assign lo_sum   = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0000, carry_in};
  assign hi_sum   = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'b0000, lo_sum[4]};

  // a ninth bit on the subtract holds the borrow out of bit 7
  assign diff = {1'b0, a} - {1'b0, b};

  // increment works on either operand
  assign inc_src = (op == ALU_INC_A) ? a : b;
  assign inc_sum = inc_src + 8'd1;

  // ---------------------------------------------------------------------------
  // result and flags
  // ---------------------------------------------------------------------------
  always_comb begin
    // flags not named by an operation keep their old value
    f_out  = f_in;
    result = a;
    case (op)
      ALU_ADD, ALU_ADC: begin
        result          = {hi_sum[3:0], lo_sum[3:0]};
        f_out[FLAG_H]   = lo_sum[4];
        f_out[FLAG_C]   = hi_sum[4];
        // overflow when both operands share a sign the result does not
        f_out[FLAG_PV]  = (a[7] == b[7]) && (result[7] != a[7]);
        f_out[FLAG_N]   = 1'b0;
      end
      ALU_SUB: begin
        result          = diff[7:0];
        // borrow into bit 4 exactly when the low nibble of a is smaller
        f_out[FLAG_H]   = a[3:0] < b[3:0];
        f_out[FLAG_C]   = diff[8];
        f_out[FLAG_PV]  = (a[7] != b[7]) && (result[7] != a[7]);
        f_out[FLAG_N]   = 1'b1;
      end
      ALU_AND: begin
        result          = a & b;
        f_out[FLAG_H]   = 1'b1;
        // PV is parity here, set for an even count of ones
        f_out[FLAG_PV]  = ~^result;
        f_out[FLAG_N]   = 1'b0;
        f_out[FLAG_C]   = 1'b0;
      end
      ALU_INC_A, ALU_INC_B: begin
        result          = inc_sum;
        f_out[FLAG_H]   = inc_src[3:0] == 4'hF;
        // the only signed overflow of an increment is 7F to 80
        f_out[FLAG_PV]  = inc_src == 8'h7F;
        f_out[FLAG_N]   = 1'b0;
      end
      ALU_CPL: begin
        result          = ~a;
        f_out[FLAG_H]   = 1'b1;
        f_out[FLAG_N]   = 1'b1;
      end
      ALU_CCF: begin
        // the old carry moves into H before C is inverted
        f_out[FLAG_H]   = f_in[FLAG_C];
        f_out[FLAG_C]   = ~f_in[FLAG_C];
      end
      ALU_PASS_B: begin
        result = b;
      end
      default: begin
        // undefined op codes hand back a with the flags untouched
      end
    endcase

    // S and Z track the result of every op that computes a new value
    if (op != ALU_CPL && op != ALU_CCF && op != ALU_PASS_B && op <= ALU_PASS_B) begin
      f_out[FLAG_S] = result[7];
      f_out[FLAG_Z] = result == 8'h00;
    end
  end

endmodule

/* hdl/z80_acc_flags.sv */
`timescale 1ns/1ns

// accumulator A and flag register F, each with a shadow for EX AF
module z80_acc_flags import z80_dp_pkg::*, z80_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ld_a,
  input  logic        ld_f,
  input  logic        res_from_alu,
  input  logic        ex_af,
  input  byte_t       bus_byte,
  input  byte_t       alu_result,
  input  byte_t       alu_flags,
  input  flag_force_t flag_force,
  output byte_t       a_q,
  output byte_t       f_q
);

  byte_t a_sh;
  byte_t f_sh;
  byte_t a_next;
  byte_t f_base;
  byte_t f_next;
  logic  f_en;

  // one flag bit after its force code has been applied
  function automatic logic forced_bit(input force_t code, input logic cur);
    case (code)
      FORCE_SET: forced_bit = 1'b1;
      FORCE_CLR: forced_bit = 1'b0;
      default:   forced_bit = cur;
    endcase
  endfunction

  // ---------------------------------------------------------------------------
  // next values
  // ---------------------------------------------------------------------------
  assign a_next = res_from_alu ? alu_result : bus_byte;

  // without ld_f the forces work on the current F
  assign f_base = ld_f ? alu_flags : f_q;

  always_comb begin
    f_next          = f_base;
    f_next[FLAG_S]  = forced_bit(flag_force.s, f_base[FLAG_S]);
    f_next[FLAG_Z]  = forced_bit(flag_force.z, f_base[FLAG_Z]);
    f_next[FLAG_H]  = forced_bit(flag_force.h, f_base[FLAG_H]);
    f_next[FLAG_PV] = forced_bit(flag_force.pv, f_base[FLAG_PV]);
    f_next[FLAG_N]  = forced_bit(flag_force.n, f_base[FLAG_N]);
    f_next[FLAG_C]  = forced_bit(flag_force.c, f_base[FLAG_C]);
  end

  // a single force code is enough to write F
  assign f_en = ld_f || flag_force != {6{FORCE_NONE}};

  // ---------------------------------------------------------------------------
  // storage
  // ---------------------------------------------------------------------------

  // the AF swap wins over every load in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_q  <= RESET_BYTE;
      f_q  <= RESET_BYTE;
      a_sh <= RESET_BYTE;
      f_sh <= RESET_BYTE;
    end else if (ex_af) begin
      a_q  <= a_sh;
      a_sh <= a_q;
      f_q  <= f_sh;
      f_sh <= f_q;
    end else begin
      if (ld_a) begin
        a_q <= a_next;
      end
      if (f_en) begin
        f_q <= f_next;
      end
    end
  end

endmodule

/* hdl/z80_datapath.sv */
`timescale 1ns/1ns

// datapath top, one internal data bus and one 16-bit address path
// holds the bus select, TEMP and the MAR around the register blocks
module z80_datapath import z80_dp_pkg::*, z80_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  dp_ctrl_t ctrl,
  input  byte_t    data_in,
  output byte_t    data_out,
  output logic     data_drive,
  output word_t    addr_out,
  output byte_t    flags
);

  byte_t data_bus;
  byte_t reg_byte;
  byte_t a_q;
  byte_t f_q;
  byte_t alu_b;
  byte_t alu_result;
  byte_t alu_flags;
  byte_t wr_byte;
  byte_t temp_q;
  word_t pair_word;
  word_t addr_path;
  word_t mar_q;

  // ---------------------------------------------------------------------------
  // data bus arbitration
  // ---------------------------------------------------------------------------

  // one encoded select replaces separate drive lines, so two sources can
  // never fight over the bus
  always_comb begin
    case (ctrl.data_src)
      DSRC_REG:  data_bus = reg_byte;
      DSRC_A:    data_bus = a_q;
      DSRC_F:    data_bus = f_q;
      DSRC_TEMP: data_bus = temp_q;
      default:   data_bus = data_in;
    endcase
  end

  // the outside sees the bus at all times and is told when the core drives it
  assign data_out   = data_bus;
  assign data_drive = ctrl.data_src != DSRC_EXT;
  assign flags      = f_q;

  // ALU operand B and the byte written back to the register file
  assign alu_b   = ctrl.alu_b_temp ? temp_q : data_bus;
  assign wr_byte = ctrl.res_from_alu ? alu_result : data_bus;

  // address path carries a register pair or the MAR
  assign addr_path = (ctrl.addr_src == ASRC_PAIR) ? pair_word : mar_q;
  assign addr_out  = addr_path;

  // ---------------------------------------------------------------------------
  // TEMP and MAR
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      temp_q <= RESET_BYTE;
      mar_q  <= {RESET_BYTE, RESET_BYTE};
    end else begin
      if (ctrl.ld_temp) begin
        temp_q <= data_bus;
      end
      // byte loads from the data bus take precedence over the word load
      if (ctrl.ld_marh || ctrl.ld_marl) begin
        if (ctrl.ld_marh) begin
          mar_q[15:8] <= data_bus;
        end
        if (ctrl.ld_marl) begin
          mar_q[7:0] <= data_bus;
        end
      end else if (ctrl.ld_mar) begin
        mar_q <= addr_path;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // register blocks
  // ---------------------------------------------------------------------------
  z80_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_reg   (ctrl.rd_reg),
    .wr_reg   (ctrl.wr_reg),
    .ld_reg   (ctrl.ld_reg),
    .ld_pair  (ctrl.ld_pair),
    .exx      (ctrl.exx),
    .ex_de_hl (ctrl.ex_de_hl),
    .wr_byte  (wr_byte),
    .rd_pair  (ctrl.rd_pair),
    .wr_pair  (ctrl.wr_pair),
    .wr_word  (addr_path),
    .rd_byte  (reg_byte),
    .rd_word  (pair_word)
  );

  z80_alu8 u_alu8 (
    .op     (ctrl.alu_op),
    .a      (a_q),
    .b      (alu_b),
    .f_in   (f_q),
    .result (alu_result),
    .f_out  (alu_flags)
  );

  z80_acc_flags u_acc_flags (
    .clk          (clk),
    .rst_n        (rst_n),
    .ld_a         (ctrl.ld_a),
    .ld_f         (ctrl.ld_f),
    .res_from_alu (ctrl.res_from_alu),
    .ex_af        (ctrl.ex_af),
    .bus_byte     (data_bus),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .flag_force   (ctrl.flag_force),
    .a_q          (a_q),
    .f_q          (f_q)
  );

endmodule

/* dv/z80_datapath_asserts.sv */
`timescale 1ns/1ns

// concurrent checks bound into the datapath top level
// they watch the control word and the top-level outputs only
module z80_datapath_asserts import z80_dp_pkg::*, z80_ctrl_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input dp_ctrl_t ctrl,
  input logic     data_drive,
  input byte_t    flags
);

  // --------------------------------------------------------------------------
  // bus ownership
  // --------------------------------------------------------------------------

  // the core drives the pins for every source except the external one
  property drive_follows_source;
    @(posedge clk) disable iff (!rst_n)
      data_drive == (ctrl.data_src != DSRC_EXT);
  endproperty

  drive_check: assert property (drive_follows_source)
    else $error("data_drive does not match the data bus source");

  // --------------------------------------------------------------------------
  // control word sanity
  // --------------------------------------------------------------------------

  // a swap already rewrites the registers, so a load in the same cycle
  // would be silently lost
  property no_load_during_swap;
    @(posedge clk) disable iff (!rst_n)
      (ctrl.exx || ctrl.ex_de_hl || ctrl.ex_af) |-> !(ctrl.ld_reg || ctrl.ld_pair);
  endproperty

  swap_check: assert property (no_load_during_swap)
    else $error("register load issued in the same cycle as a swap");

  // F comes out of reset cleared
  property flags_clear_after_reset;
    @(posedge clk)
      (rst_n && !$past(rst_n)) |-> flags == RESET_BYTE;
  endproperty

  reset_check: assert property (flags_clear_after_reset)
    else $error("flags are not zero in the first cycle after reset");

endmodule

/* dv/z80_datapath_tb.sv */
`timescale 1ns/1ns

// directed and random testbench for the datapath top level
// every operation takes one clock, inputs change 1 ns after the rising edge and
// outputs are compared mid-cycle, when they have settled
module z80_datapath_tb import z80_dp_pkg::*, z80_ctrl_pkg::*; ();

  // rough count of clocked operations in the whole run, used by the watchdog
  localparam int OP_COUNT = 320;

  logic     clk;
  logic     rst_n;
  dp_ctrl_t ctrl;
  byte_t    data_in;
  byte_t    data_out;
  logic     data_drive;
  word_t    addr_out;
  byte_t    flags;

  integer seed;

  // reference model state, kept in step with every strobe the stimulus issues
  byte_t exp_regs [REG_COUNT];
  byte_t exp_shadow [SHADOW_COUNT];
  byte_t exp_a;
  byte_t exp_f;
  byte_t exp_a_sh;
  byte_t exp_f_sh;
  byte_t exp_temp;
  word_t exp_mar;

  // flag bit for each force slot, same order as the fields of flag_force_t
  int      flag_bits [6] = '{FLAG_S, FLAG_Z, FLAG_H, FLAG_PV, FLAG_N, FLAG_C};
  alu_op_t arith_ops [8] = '{ALU_ADD, ALU_ADC, ALU_SUB, ALU_AND,
                             ALU_CPL, ALU_CCF, ALU_INC_A, ALU_PASS_B};

  z80_datapath DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .data_in    (data_in),
    .data_out   (data_out),
    .data_drive (data_drive),
    .addr_out   (addr_out),
    .flags      (flags)
  );

  bind z80_datapath z80_datapath_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .data_drive (data_drive),
    .flags      (flags)
  );

  always #4 clk = ~clk;

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  // one clock of stimulus, the strobes in c are taken at the following edge
  task automatic drive(input dp_ctrl_t c, input byte_t d);
    @(posedge clk);
    #1;
    ctrl    = c;
    data_in = d;
    #3;
  endtask

  task automatic compare(input string name, input logic [15:0] exp_val,
                         input logic [15:0] act_val);
    assert (act_val === exp_val) else begin
      $display("Error %s expected %h actual %h", name, exp_val, act_val);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // upper register of a pair, the lower one always follows it in reg8_t
  function automatic reg8_t pair_high(input pair_t p);
    case (p)
      PAIR_BC: return R_B;
      PAIR_DE: return R_D;
      PAIR_HL: return R_H;
      PAIR_SP: return R_SPH;
      default: return R_PCH;
    endcase
  endfunction

  function automatic reg8_t pair_low(input pair_t p);
    return reg8_t'(pair_high(p) + 4'd1);
  endfunction

  // force code on a single flag, every other flag left alone
  function automatic flag_force_t force_one(input int k, input force_t code);
    flag_force_t ff;
    ff = '0;
    case (k)
      0: ff.s = code;
      1: ff.z = code;
      2: ff.h = code;
      3: ff.pv = code;
      4: ff.n = code;
      default: ff.c = code;
    endcase
    return ff;
  endfunction

  // expected {result, flags} worked out in plain integer arithmetic
  function automatic word_t alu_expect(input alu_op_t op, input byte_t a, input byte_t b,
                                       input byte_t f);
    byte_t r;
    byte_t nf;
    byte_t src;
    int    ci;
    int    total;
    int    stotal;
    r   = a;
    nf  = f;
    ci  = (op == ALU_ADC && f[FLAG_C]) ? 1 : 0;
    src = (op == ALU_INC_A) ? a : b;
    case (op)
      ALU_ADD, ALU_ADC: begin
        total       = int'(a) + int'(b) + ci;
        stotal      = int'($signed(a)) + int'($signed(b)) + ci;
        r           = 8'(total);
        nf[FLAG_H]  = (int'(a) % 16) + (int'(b) % 16) + ci > 15;
        nf[FLAG_C]  = total > 255;
        nf[FLAG_PV] = stotal > 127 || stotal < -128;
        nf[FLAG_N]  = 1'b0;
      end
      ALU_SUB: begin
        total       = int'(a) - int'(b);
        stotal      = int'($signed(a)) - int'($signed(b));
        r           = 8'(total);
        nf[FLAG_H]  = (int'(a) % 16) < (int'(b) % 16);
        nf[FLAG_C]  = total < 0;
        nf[FLAG_PV] = stotal > 127 || stotal < -128;
        nf[FLAG_N]  = 1'b1;
      end
      ALU_AND: begin
        r           = a & b;
        nf[FLAG_H]  = 1'b1;
        nf[FLAG_PV] = ($countones(r) % 2) == 0;
        nf[FLAG_N]  = 1'b0;
        nf[FLAG_C]  = 1'b0;
      end
      ALU_INC_A, ALU_INC_B: begin
        r           = 8'(int'(src) + 1);
        nf[FLAG_H]  = (int'(src) % 16) == 15;
        nf[FLAG_PV] = src == 8'h7F;
        nf[FLAG_N]  = 1'b0;
      end
      ALU_CPL: begin
        r          = ~a;
        nf[FLAG_H] = 1'b1;
        nf[FLAG_N] = 1'b1;
      end
      ALU_CCF: begin
        nf[FLAG_H] = f[FLAG_C];
        nf[FLAG_C] = !f[FLAG_C];
      end
      default: begin
        r = b;
      end
    endcase
    if (op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_AND, ALU_INC_A, ALU_INC_B}) begin
      nf[FLAG_S] = r[7];
      nf[FLAG_Z] = r == 8'h00;
    end
    return {r, nf};
  endfunction

  task automatic load_reg(input reg8_t r, input byte_t v);
    dp_ctrl_t c;
    c        = '0;
    c.ld_reg = 1'b1;
    c.wr_reg = r;
    drive(c, v);
    exp_regs[r] = v;
  endtask

  task automatic read_reg(input string name, input reg8_t r);
    dp_ctrl_t c;
    c          = '0;
    c.data_src = DSRC_REG;
    c.rd_reg   = r;
    drive(c, 8'h00);
    compare(name, {8'h00, exp_regs[r]}, {8'h00, data_out});
    compare({name, " drive"}, 16'h0001, {15'h0000, data_drive});
  endtask

  task automatic read_pair(input string name, input pair_t p);
    dp_ctrl_t c;
    c          = '0;
    c.addr_src = ASRC_PAIR;
    c.rd_pair  = p;
    drive(c, 8'h00);
    compare(name, {exp_regs[pair_high(p)], exp_regs[pair_low(p)]}, addr_out);
  endtask

  // A, F or TEMP seen on data_out, with the flag output checked as well
  task automatic read_src(input string name, input data_src_t s, input byte_t exp_val);
    dp_ctrl_t c;
    c          = '0;
    c.data_src = s;
    drive(c, 8'h00);
    compare(name, {8'h00, exp_val}, {8'h00, data_out});
    compare({name, " flags"}, {8'h00, exp_f}, {8'h00, flags});
  endtask

  // MAR built a byte at a time from data_in, high byte first
  task automatic load_mar(input word_t w);
    dp_ctrl_t c;
    c         = '0;
    c.ld_marh = 1'b1;
    drive(c, w[15:8]);
    c         = '0;
    c.ld_marl = 1'b1;
    drive(c, w[7:0]);
    exp_mar = w;
    c = '0;
    drive(c, 8'h00);
    compare("mar bytes", exp_mar, addr_out);
  endtask

  task automatic swap_general();
    dp_ctrl_t c;
    byte_t    t;
    c     = '0;
    c.exx = 1'b1;
    drive(c, 8'h00);
    for (int i = 0; i < SHADOW_COUNT; i++) begin
      t             = exp_regs[i];
      exp_regs[i]   = exp_shadow[i];
      exp_shadow[i] = t;
    end
  endtask

  task automatic swap_af();
    dp_ctrl_t c;
    byte_t    t;
    c       = '0;
    c.ex_af = 1'b1;
    drive(c, 8'h00);
    t        = exp_a;
    exp_a    = exp_a_sh;
    exp_a_sh = t;
    t        = exp_f;
    exp_f    = exp_f_sh;
    exp_f_sh = t;
    read_src("ex af a", DSRC_A, exp_a);
  endtask

  // --------------------------------------------------------------------------
  // watchdog
  // --------------------------------------------------------------------------
  initial begin
    #(OP_COUNT * 8 * 2);
    $display("watchdog expired, the run did not finish in %0d ns", OP_COUNT * 16);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin
    dp_ctrl_t c;
    byte_t    v;
    byte_t    t;
    word_t    res;
    alu_op_t  op;
    force_t   fc;
    clk      = 1'b0;
    rst_n    = 1'b0;
    ctrl     = '0;
    data_in  = 8'h00;
    seed     = 33361;
    exp_a    = 8'h00;
    exp_f    = 8'h00;
    exp_a_sh = 8'h00;
    exp_f_sh = 8'h00;
    exp_temp = 8'h00;
    exp_mar  = 16'h0000;
    for (int i = 0; i < REG_COUNT; i++) begin
      exp_regs[i] = 8'h00;
    end
    for (int i = 0; i < SHADOW_COUNT; i++) begin
      exp_shadow[i] = 8'h00;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // everything reads zero after reset and the core does not drive data
    c = '0;
    drive(c, 8'h5A);
    compare("reset drive", 16'h0000, {15'h0000, data_drive});
    compare("reset bus", 16'h005A, {8'h00, data_out});
    compare("reset addr", 16'h0000, addr_out);
    for (int i = 0; i < REG_COUNT; i++) begin
      read_reg("reset reg", reg8_t'(i));
    end
    read_src("reset a", DSRC_A, 8'h00);
    read_src("reset f", DSRC_F, 8'h00);
    read_src("reset temp", DSRC_TEMP, 8'h00);

    // byte loads, byte reads and pair reads
    for (int i = 0; i < REG_COUNT; i++) begin
      load_reg(reg8_t'(i), 8'($random(seed)));
    end
    for (int i = 0; i < REG_COUNT; i++) begin
      read_reg("byte readback", reg8_t'(i));
    end
    for (int p = 0; p < 5; p++) begin
      read_pair("pair readback", pair_t'(p));
    end

    // MAR from data_in, then each pair written from the MAR path
    for (int p = 0; p < 5; p++) begin
      load_mar(16'($random(seed)));
      c          = '0;
      c.ld_pair  = 1'b1;
      c.wr_pair  = pair_t'(p);
      c.addr_src = ASRC_MAR;
      drive(c, 8'h00);
      exp_regs[pair_high(pair_t'(p))] = exp_mar[15:8];
      exp_regs[pair_low(pair_t'(p))]  = exp_mar[7:0];
      read_pair("pair from mar", pair_t'(p));
    end

    // whole MAR taken from a register pair, then shown again under ASRC_MAR
    c          = '0;
    c.addr_src = ASRC_PAIR;
    c.rd_pair  = PAIR_DE;
    c.ld_mar   = 1'b1;
    drive(c, 8'h00);
    exp_mar = {exp_regs[R_D], exp_regs[R_E]};
    c = '0;
    drive(c, 8'h00);
    compare("mar word", exp_mar, addr_out);

    // ALU on random A and TEMP, result back into A and flags into F
    for (int n = 0; n < 24; n++) begin
      c      = '0;
      c.ld_a = 1'b1;
      exp_a  = 8'($random(seed));
      drive(c, exp_a);
      c         = '0;
      c.ld_temp = 1'b1;
      exp_temp  = 8'($random(seed));
      drive(c, exp_temp);
      op             = arith_ops[n % 8];
      res            = alu_expect(op, exp_a, exp_temp, exp_f);
      c              = '0;
      c.alu_op       = op;
      c.alu_b_temp   = 1'b1;
      c.res_from_alu = 1'b1;
      c.ld_a         = 1'b1;
      c.ld_f         = 1'b1;
      drive(c, 8'h00);
      exp_a = res[15:8];
      exp_f = res[7:0];
      read_src($sformatf("alu %s", op.name()), DSRC_A, exp_a);
    end
    read_src("temp readback", DSRC_TEMP, exp_temp);

    // INC_B on a register read over the bus and written back, FF wraps to 00
    for (int k = 0; k < 3; k++) begin
      v = (k == 0) ? 8'hFF : (k == 1) ? 8'h7F : 8'($random(seed));
      load_reg(reg8_t'(k), v);
      res            = alu_expect(ALU_INC_B, exp_a, v, exp_f);
      c              = '0;
      c.data_src     = DSRC_REG;
      c.rd_reg       = reg8_t'(k);
      c.alu_op       = ALU_INC_B;
      c.res_from_alu = 1'b1;
      c.ld_reg       = 1'b1;
      c.wr_reg       = reg8_t'(k);
      c.ld_f         = 1'b1;
      drive(c, 8'h00);
      exp_regs[k] = res[15:8];
      exp_f       = res[7:0];
      read_reg("inc reg", reg8_t'(k));
      compare("inc flags", {8'h00, exp_f}, {8'h00, flags});
    end

    // force codes alone move each flag away from its current value and back
    for (int k = 0; k < 6; k++) begin
      for (int s = 0; s < 2; s++) begin
        fc           = exp_f[flag_bits[k]] ? FORCE_CLR : FORCE_SET;
        c            = '0;
        c.flag_force = force_one(k, fc);
        drive(c, 8'h00);
        exp_f[flag_bits[k]] = (fc == FORCE_SET);
        read_src($sformatf("force %s", fc.name()), DSRC_F, exp_f);
      end
    end

    // forces on top of ALU flags, AND clears C and sets H before the override
    res            = alu_expect(ALU_AND, exp_a, exp_temp, exp_f);
    c              = '0;
    c.alu_op       = ALU_AND;
    c.alu_b_temp   = 1'b1;
    c.ld_f         = 1'b1;
    c.flag_force.c = FORCE_SET;
    c.flag_force.h = FORCE_CLR;
    drive(c, 8'h00);
    exp_f         = res[7:0];
    exp_f[FLAG_C] = 1'b1;
    exp_f[FLAG_H] = 1'b0;
    read_src("force with ld_f", DSRC_F, exp_f);

    // EXX twice, the second one brings the first set back
    swap_general();
    for (int i = 0; i < SHADOW_COUNT; i++) begin
      read_reg("exx first", reg8_t'(i));
    end
    for (int i = 0; i < SHADOW_COUNT; i++) begin
      load_reg(reg8_t'(i), 8'($random(seed)));
    end
    swap_general();
    for (int i = 0; i < SHADOW_COUNT; i++) begin
      read_reg("exx second", reg8_t'(i));
    end

    // EX DE,HL
    c          = '0;
    c.ex_de_hl = 1'b1;
    drive(c, 8'h00);
    t             = exp_regs[R_D];
    exp_regs[R_D] = exp_regs[R_H];
    exp_regs[R_H] = t;
    t             = exp_regs[R_E];
    exp_regs[R_E] = exp_regs[R_L];
    exp_regs[R_L] = t;
    read_pair("ex de hl de", PAIR_DE);
    read_pair("ex de hl hl", PAIR_HL);

    // EX AF out to the zero shadows and back again with a new A
    swap_af();
    c      = '0;
    c.ld_a = 1'b1;
    exp_a  = 8'($random(seed));
    drive(c, exp_a);
    swap_af();
    read_src("ex af f", DSRC_F, exp_f);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* filelist.f */
hdl/z80_dp_pkg.sv
hdl/z80_ctrl_pkg.sv
hdl/z80_regfile.sv
hdl/z80_alu8.sv
hdl/z80_acc_flags.sv
hdl/z80_datapath.sv
dv/z80_datapath_asserts.sv
dv/z80_datapath_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the datapath testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module z80_datapath_tb \
  -o z80_datapath_sim
sim_out=$(./obj_dir/z80_datapath_sim 2>&1) || true
echo "$sim_out"
if echo "$sim_out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
